// File: source/posit_accum_pkg.sv
// Posit accumulator shared definitions
// Word layout, field struct and the two views of a serialized word
`default_nettype none

package posit_accum_pkg;

    localparam int SCALE_W = 9;
    localparam int FRAC_W = 20;
    localparam int MANT_W = FRAC_W + 1;
    localparam int WORD_W = 32;

    // Clock edges from start sampled to done
    localparam int PIPE_DEPTH = 5;

    // Top bit down: sign, scale, fraction, inf, zero
    typedef struct packed {
        logic sgn;
        logic signed [SCALE_W-1:0] scale;
        logic [FRAC_W-1:0] fraction;
        logic inf;
        logic zero;
    } posit_fields_t;

    // Serialized port word or its decoded fields
    typedef union packed {
        logic [WORD_W-1:0] bits;
        posit_fields_t fields;
    } posit_word_u;

    // Canonical zero, also the reset state of every field register
    localparam posit_fields_t POSIT_ZERO = '{sgn: 1'b0, scale: '0, fraction: '0,
                                             inf: 1'b0, zero: 1'b1};

endpackage

`default_nettype wire

// File: source/accum_operand_stage.sv
// Accumulator operand stage
// Captures the new operand, compares it with the running sum and orders the pair
`timescale 1ns/1ns
`default_nettype none

module accum_operand_stage
    import posit_accum_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  posit_fields_t in_fields,
    input  posit_fields_t sum_fields,
    output posit_fields_t hi,
    output posit_fields_t low,
    output logic          subtract,
    output logic          valid
);

    posit_fields_t operand_q;
    logic start_q;
    logic op_is_hi;

    // Operand register, an idle or zero-flagged input becomes canonical zero
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            operand_q <= POSIT_ZERO;
            start_q <= 1'b0;
        end
        else
        begin
            start_q <= start;
            if (!start || in_fields.zero)
                operand_q <= POSIT_ZERO;
            else
                operand_q <= in_fields;
        end
    end

    // Magnitude compare, a zero operand always loses
    // Sum comes straight from the result registers so the loop stays PIPE_DEPTH long
    always_comb
    begin
        if (sum_fields.zero)
            op_is_hi = 1'b1;
        else if (operand_q.zero)
            op_is_hi = 1'b0;
        else if (operand_q.scale != sum_fields.scale)
            op_is_hi = operand_q.scale > sum_fields.scale;
        else
            op_is_hi = operand_q.fraction >= sum_fields.fraction;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            hi <= POSIT_ZERO;
            low <= POSIT_ZERO;
            subtract <= 1'b0;
            valid <= 1'b0;
        end
        else
        begin
            hi <= op_is_hi ? operand_q : sum_fields;
            low <= op_is_hi ? sum_fields : operand_q;
            // Unequal signs mean a subtraction
            subtract <= operand_q.sgn ^ sum_fields.sgn;
            valid <= start_q;
        end
    end

    a_hi_not_smaller: assert property (@(posedge clk) disable iff (rst)
        !low.zero |-> !hi.zero && (hi.scale > low.scale ||
            (hi.scale == low.scale && hi.fraction >= low.fraction)));

endmodule

`default_nettype wire

// File: source/align_stage.sv
// Mantissa alignment stage
// Shifts the smaller mantissa right by the scale difference and flags lost bits
`timescale 1ns/1ns
`default_nettype none

module align_stage
    import posit_accum_pkg::*;
#(
    parameter int GUARD_W = 3
)
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        valid_in,
    input  posit_fields_t               hi_in,
    input  posit_fields_t               low_in,
    input  logic                        subtract_in,
    output posit_fields_t               hi,
    output posit_fields_t               low,
    output logic [MANT_W+GUARD_W-1:0]   low_aligned,
    output logic                        subtract,
    output logic                        lost_bits,
    output logic                        valid
);

    localparam int ADD_W = MANT_W + GUARD_W;

    logic signed [SCALE_W:0] scale_diff;
    logic [ADD_W-1:0] low_wide;
    logic [2*ADD_W-1:0] shifted;
    logic saturate;

    // One extra bit so the difference of two signed scales cannot wrap
    assign scale_diff = hi_in.scale - low_in.scale;

    // Hidden bit clear for zero, guard bits appended below the fraction
    assign low_wide = ADD_W'({~low_in.zero, low_in.fraction}) << GUARD_W;

    // Lower half catches whatever falls off the adder width
    assign shifted = {low_wide, {ADD_W{1'b0}}} >> $unsigned(scale_diff);
    assign saturate = scale_diff >= ADD_W;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            hi <= POSIT_ZERO;
            low <= POSIT_ZERO;
            low_aligned <= '0;
            subtract <= 1'b0;
            lost_bits <= 1'b0;
            valid <= 1'b0;
        end
        else
        begin
            hi <= hi_in;
            low <= low_in;
            low_aligned <= shifted[2*ADD_W-1:ADD_W];
            lost_bits <= saturate ? |low_wide : |shifted[ADD_W-1:0];
            subtract <= subtract_in;
            valid <= valid_in;
        end
    end

    // Relies on the swap in the operand stage
    a_diff_positive: assert property (@(posedge clk) disable iff (rst)
        !low_in.zero |-> scale_diff >= 0);

endmodule

`default_nettype wire

// File: source/fraction_addsub_stage.sv
// Mantissa add/subtract stage
// Adds or subtracts the aligned mantissas and builds the result header
`timescale 1ns/1ns
`default_nettype none

module fraction_addsub_stage
    import posit_accum_pkg::*;
#(
    parameter int GUARD_W = 3
)
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        valid_in,
    input  posit_fields_t               hi_in,
    input  posit_fields_t               low_in,
    input  logic [MANT_W+GUARD_W-1:0]   low_aligned,
    input  logic                        subtract_in,
    input  logic                        lost_bits_in,
    output logic [MANT_W+GUARD_W:0]     raw_sum,
    output posit_fields_t               sum_hdr,
    output logic                        lost_bits,
    output logic                        valid
);

    localparam int ADD_W = MANT_W + GUARD_W;

    logic [ADD_W-1:0] hi_wide;
    logic same_mag;
    posit_fields_t hdr_next;

    assign hi_wide = ADD_W'({~hi_in.zero, hi_in.fraction}) << GUARD_W;

    // Equal nonzero magnitudes cancel on a subtraction
    assign same_mag = !low_in.zero && hi_in.scale == low_in.scale &&
                      hi_in.fraction == low_in.fraction;

    always_comb
    begin
        hdr_next = POSIT_ZERO;
        hdr_next.sgn = hi_in.sgn;
        hdr_next.scale = hi_in.scale;
        hdr_next.inf = hi_in.inf | low_in.inf;
        hdr_next.zero = (hi_in.zero && low_in.zero) || (subtract_in && same_mag);
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            raw_sum <= '0;
            sum_hdr <= POSIT_ZERO;
            lost_bits <= 1'b0;
            valid <= 1'b0;
        end
        else
        begin
            // hi is never smaller, so the difference stays non-negative
            if (subtract_in)
                raw_sum <= {1'b0, hi_wide} - {1'b0, low_aligned};
            else
                raw_sum <= {1'b0, hi_wide} + {1'b0, low_aligned};
            sum_hdr <= hdr_next;
            lost_bits <= lost_bits_in;
            valid <= valid_in;
        end
    end

endmodule

`default_nettype wire

// File: source/leading_one_stage.sv
// Leading one detection stage
// Counts leading zeros of the raw sum and adjusts the result scale
`timescale 1ns/1ns
`default_nettype none

module leading_one_stage
    import posit_accum_pkg::*;
#(
    parameter int GUARD_W = 3
)
(
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        valid_in,
    input  logic [MANT_W+GUARD_W:0]                     raw_sum_in,
    input  posit_fields_t                               sum_hdr_in,
    input  logic                                        lost_bits_in,
    output logic [MANT_W+GUARD_W:0]                     raw_sum,
    output logic [$clog2(MANT_W+GUARD_W+2)-1:0]         norm_shift,
    output posit_fields_t                               sum_hdr,
    output logic                                        lost_bits,
    output logic                                        valid
);

    localparam int ADD_W = MANT_W + GUARD_W;
    localparam int SHIFT_W = $clog2(ADD_W + 2);

    logic [SHIFT_W-1:0] lz;
    logic signed [SCALE_W-1:0] next_scale;
    posit_fields_t hdr_next;

    // Leading zeros over the full sum including the carry bit
    always_comb
    begin
        lz = SHIFT_W'(ADD_W + 1);
        for (int i = 0; i <= ADD_W; i++)
        begin
            if (raw_sum_in[i])
                lz = SHIFT_W'(ADD_W - i);
        end
    end

    // Carry gives lz of 0 and a scale up by one
    // Otherwise the scale drops by the zeros below the carry position
    assign next_scale = sum_hdr_in.scale + SCALE_W'(1) - SCALE_W'(lz);

    always_comb
    begin
        hdr_next = sum_hdr_in;
        hdr_next.scale = next_scale;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            raw_sum <= '0;
            norm_shift <= '0;
            sum_hdr <= POSIT_ZERO;
            lost_bits <= 1'b0;
            valid <= 1'b0;
        end
        else
        begin
            raw_sum <= raw_sum_in;
            norm_shift <= lz;
            sum_hdr <= hdr_next;
            lost_bits <= lost_bits_in;
            valid <= valid_in;
        end
    end

endmodule

`default_nettype wire

// File: source/normalize_stage.sv
// Normalization stage
// Moves the leading one to the top, truncates the fraction and drives the outputs
`timescale 1ns/1ns
`default_nettype none

module normalize_stage
    import posit_accum_pkg::*;
#(
    parameter int GUARD_W = 3
)
(
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        valid_in,
    input  logic [MANT_W+GUARD_W:0]                     raw_sum_in,
    input  logic [$clog2(MANT_W+GUARD_W+2)-1:0]         norm_shift_in,
    input  posit_fields_t                               sum_hdr_in,
    input  logic                                        lost_bits_in,
    output posit_fields_t                               result_fields,
    output logic                                        done,
    output logic                                        truncated
);

    localparam int ADD_W = MANT_W + GUARD_W;

    logic [ADD_W:0] sum_norm;
    posit_fields_t next_fields;

    // Leading one lands on the top bit
    assign sum_norm = raw_sum_in << norm_shift_in;

    always_comb
    begin
        next_fields = sum_hdr_in;
        // Fraction sits just below the leading one and the guard bits drop off
        next_fields.fraction = sum_norm[ADD_W-1 -: FRAC_W];
        if (sum_hdr_in.zero)
        begin
            // Clean zero for the feedback loop keeps the inf flag
            next_fields = POSIT_ZERO;
            next_fields.inf = sum_hdr_in.inf;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            result_fields <= POSIT_ZERO;
            done <= 1'b0;
            truncated <= 1'b0;
        end
        else
        begin
            result_fields <= next_fields;
            done <= valid_in;
            truncated <= lost_bits_in;
        end
    end

    a_zero_canonical: assert property (@(posedge clk) disable iff (rst)
        result_fields.zero |-> !result_fields.sgn &&
            result_fields.scale == '0 && result_fields.fraction == '0);

endmodule

`default_nettype wire

// File: source/posit_accumulator.sv
// Pipelined posit accumulator
// Adds each started operand to one of PIPE_DEPTH interleaved running sums
`timescale 1ns/1ns
`default_nettype none

module posit_accumulator
    import posit_accum_pkg::*;
#(
    parameter int GUARD_W = 3
)
(
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic [WORD_W-1:0] in_word,
    output logic [WORD_W-1:0] result,
    output logic              done,
    output logic              truncated
);

    localparam int ADD_W = MANT_W + GUARD_W;
    localparam int SHIFT_W = $clog2(ADD_W + 2);

    posit_word_u in_u;
    posit_word_u res_u;

    posit_fields_t op_hi, op_low;
    logic op_subtract, op_valid;

    posit_fields_t al_hi, al_low;
    logic [ADD_W-1:0] al_low_aligned;
    logic al_subtract, al_lost, al_valid;

    logic [ADD_W:0] as_raw_sum;
    posit_fields_t as_hdr;
    logic as_lost, as_valid;

    logic [ADD_W:0] lo_raw_sum;
    logic [SHIFT_W-1:0] lo_norm_shift;
    posit_fields_t lo_hdr;
    logic lo_lost, lo_valid;

    assign in_u.bits = in_word;
    assign result = res_u.bits;

    // Result fields loop back as the running sum
    accum_operand_stage u_operand (
        .clk(clk), .rst(rst), .start(start),
        .in_fields(in_u.fields), .sum_fields(res_u.fields),
        .hi(op_hi), .low(op_low), .subtract(op_subtract), .valid(op_valid)
    );

    align_stage #(.GUARD_W(GUARD_W)) u_align (
        .clk(clk), .rst(rst), .valid_in(op_valid),
        .hi_in(op_hi), .low_in(op_low), .subtract_in(op_subtract),
        .hi(al_hi), .low(al_low), .low_aligned(al_low_aligned),
        .subtract(al_subtract), .lost_bits(al_lost), .valid(al_valid)
    );

    fraction_addsub_stage #(.GUARD_W(GUARD_W)) u_addsub (
        .clk(clk), .rst(rst), .valid_in(al_valid),
        .hi_in(al_hi), .low_in(al_low), .low_aligned(al_low_aligned),
        .subtract_in(al_subtract), .lost_bits_in(al_lost),
        .raw_sum(as_raw_sum), .sum_hdr(as_hdr), .lost_bits(as_lost), .valid(as_valid)
    );

    leading_one_stage #(.GUARD_W(GUARD_W)) u_lead (
        .clk(clk), .rst(rst), .valid_in(as_valid),
        .raw_sum_in(as_raw_sum), .sum_hdr_in(as_hdr), .lost_bits_in(as_lost),
        .raw_sum(lo_raw_sum), .norm_shift(lo_norm_shift), .sum_hdr(lo_hdr),
        .lost_bits(lo_lost), .valid(lo_valid)
    );

    normalize_stage #(.GUARD_W(GUARD_W)) u_norm (
        .clk(clk), .rst(rst), .valid_in(lo_valid),
        .raw_sum_in(lo_raw_sum), .norm_shift_in(lo_norm_shift),
        .sum_hdr_in(lo_hdr), .lost_bits_in(lo_lost),
        .result_fields(res_u.fields), .done(done), .truncated(truncated)
    );

endmodule

`default_nettype wire

// File: verif/posit_accumulator_tb.sv
// Testbench for the pipelined posit accumulator
// Applies a table of operands to one accumulation slot and checks each result
`timescale 1ns/1ns
`default_nettype none

module posit_accumulator_tb
    import posit_accum_pkg::*;
;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 10;
    localparam int GUARD_W = 3;

    // Common fractions, hidden one implied
    localparam logic [FRAC_W-1:0] F_1_0 = '0;
    localparam logic [FRAC_W-1:0] F_1_5 = FRAC_W'(1) << (FRAC_W - 1);
    localparam logic [FRAC_W-1:0] F_1_25 = FRAC_W'(1) << (FRAC_W - 2);
    localparam logic [FRAC_W-1:0] F_LSB = FRAC_W'(1);

    // Shift that pushes the lowest fraction bit past the guard bits
    localparam int LOSS_SHIFT = GUARD_W + 2;

    typedef struct packed {
        logic group;
        logic start;
        logic [WORD_W-1:0] in_word;
        logic [WORD_W-1:0] exp_word;
        logic exp_trunc;
    } row_t;

    logic clk;
    logic rst;
    logic start;
    logic [WORD_W-1:0] in_word;
    logic [WORD_W-1:0] result;
    logic done;
    logic truncated;

    row_t rows[$];
    int errors;
    int checks;

    posit_accumulator #(.GUARD_W(GUARD_W)) uut (
        .clk(clk), .rst(rst), .start(start), .in_word(in_word),
        .result(result), .done(done), .truncated(truncated)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Layout from the top bit down: sign, scale, fraction, inf, zero
    function automatic logic [WORD_W-1:0] make_word(input logic sgn, input int scale,
                                                    input logic [FRAC_W-1:0] frac,
                                                    input logic inf, input logic zero);
        logic [SCALE_W-1:0] sc;
        sc = scale[SCALE_W-1:0];
        return {sgn, sc, frac, inf, zero};
    endfunction

    task automatic add_row(input logic group, input logic row_start,
                           input logic [WORD_W-1:0] in_w, input logic [WORD_W-1:0] exp_w,
                           input logic exp_t);
        row_t r;
        r.group = group;
        r.start = row_start;
        r.in_word = in_w;
        r.exp_word = exp_w;
        r.exp_trunc = exp_t;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // Lone operand passes through
        add_row(1, 1, make_word(0, 3, F_1_5, 0, 0), make_word(0, 3, F_1_5, 0, 0), 0);
        // Equal operands carry out
        add_row(1, 1, make_word(0, 3, F_1_0, 0, 0), make_word(0, 3, F_1_0, 0, 0), 0);
        add_row(0, 1, make_word(0, 3, F_1_0, 0, 0), make_word(0, 4, F_1_0, 0, 0), 0);
        // 1.5 - 1.0 renormalizes, then the negated sum cancels
        add_row(1, 1, make_word(0, 2, F_1_5, 0, 0), make_word(0, 2, F_1_5, 0, 0), 0);
        add_row(0, 1, make_word(1, 2, F_1_0, 0, 0), make_word(0, 1, F_1_0, 0, 0), 0);
        add_row(0, 1, make_word(1, 1, F_1_0, 0, 0), make_word(0, 0, F_1_0, 0, 1), 0);
        add_row(0, 1, make_word(0, 5, F_1_25, 0, 0), make_word(0, 5, F_1_25, 0, 0), 0);
        // Shift far past the adder width, then a short exact shift, then a lossy one
        add_row(1, 1, make_word(0, 10, F_1_0, 0, 0), make_word(0, 10, F_1_0, 0, 0), 0);
        add_row(0, 1, make_word(0, 10 - (2 * (MANT_W + GUARD_W) + 6), F_1_0, 0, 0),
                make_word(0, 10, F_1_0, 0, 0), 1);
        add_row(0, 1, make_word(0, 8, F_1_0, 0, 0), make_word(0, 10, F_1_25, 0, 0), 0);
        add_row(0, 1, make_word(0, 10 - LOSS_SHIFT, F_LSB, 0, 0),
                make_word(0, 10, F_1_25 | (FRAC_W'(1) << (FRAC_W - LOSS_SHIFT)), 0, 0), 1);
        // inf sticks to the sum
        add_row(1, 1, make_word(0, 0, F_1_0, 1, 0), make_word(0, 0, F_1_0, 1, 0), 0);
        add_row(0, 1, make_word(0, 0, F_1_0, 0, 0), make_word(0, 1, F_1_0, 1, 0), 0);
        // Idle and zero-flagged rows keep the sum
        add_row(1, 1, make_word(0, 3, F_1_0, 0, 0), make_word(0, 3, F_1_0, 0, 0), 0);
        add_row(0, 0, make_word(0, 7, F_1_5, 0, 0), make_word(0, 3, F_1_0, 0, 0), 0);
        add_row(0, 1, make_word(0, 7, F_1_5, 0, 1), make_word(0, 3, F_1_0, 0, 0), 0);
        add_row(0, 1, make_word(0, 3, F_1_0, 0, 0), make_word(0, 4, F_1_0, 0, 0), 0);
    endtask

    task automatic flag_error(input string msg);
        errors++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    task automatic check_row(input int idx);
        row_t r;
        r = rows[idx];
        checks++;
        if (done !== r.start)
            flag_error($sformatf("row %0d done %b, expected %b", idx, done, r.start));
        if (result !== r.exp_word)
            flag_error($sformatf("row %0d result %h, expected %h", idx, result, r.exp_word));
        if (truncated !== r.exp_trunc)
            flag_error($sformatf("row %0d truncated %b, expected %b", idx, truncated,
                                 r.exp_trunc));
    endtask

    task automatic check_idle();
        checks++;
        if (done !== 1'b0)
            flag_error("done high on a cycle with no result due");
    endtask

    task automatic pulse_reset();
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
    endtask

    // Watchdog sized from the table length
    initial
    begin
        int limit_ns;
        #1;
        limit_ns = rows.size() * (PIPE_DEPTH + 4) * CLK_PERIOD
                   + RESET_CYCLES * CLK_PERIOD + 200;
        #(limit_ns);
        $display("Simulation did not finish before the watchdog limit of %0d ns", limit_ns);
        $display("Errors found");
        $finish;
    end

    initial
    begin
        int pending;
        int i;
        int c;
        errors = 0;
        checks = 0;
        rst = 1'b1;
        start = 1'b0;
        in_word = '0;
        build_table();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // Idle outputs after reset
        checks++;
        if (result !== make_word(0, 0, F_1_0, 0, 1) || done !== 1'b0 || truncated !== 1'b0)
            flag_error($sformatf("reset state result %h done %b truncated %b",
                                 result, done, truncated));

        pending = -1;
        for (i = 0; i < rows.size(); i++)
        begin
            if (rows[i].group)
            begin
                // Collect the last result of the previous group first
                if (pending >= 0)
                begin
                    @(negedge clk);
                    check_row(pending);
                    pending = -1;
                end
                pulse_reset();
            end
            start = rows[i].start;
            in_word = rows[i].in_word;
            // The previous row of this slot comes out on the edge that samples the new one
            for (c = 1; c <= PIPE_DEPTH; c++)
            begin
                @(negedge clk);
                if (c == 1)
                begin
                    start = 1'b0;
                    if (pending >= 0)
                        check_row(pending);
                    else
                        check_idle();
                end
                else
                    check_idle();
            end
            pending = i;
        end
        @(negedge clk);
        check_row(pending);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
source/posit_accum_pkg.sv
source/accum_operand_stage.sv
source/align_stage.sv
source/fraction_addsub_stage.sv
source/leading_one_stage.sv
source/normalize_stage.sv
source/posit_accumulator.sv
verif/posit_accumulator_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the posit accumulator testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module posit_accumulator_tb -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vposit_accumulator_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi

echo "Simulation PASSED"
exit 0
